// File: sources.f
+incdir+tb
verilog/rect_pkg.sv
verilog/shape_sequencer.sv
verilog/rect_fill_drawer.sv
verilog/framebuffer.sv
verilog/scanout_480p.sv
verilog/rect_display_top.sv
tb/tb_rect_display.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from verilog/ where the palette lives
# the run passes only if the output holds the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_rect_display -f sources.f &&
(cd verilog && ../obj_dir/Vtb_rect_display) | tee /dev/stderr | grep -qx "No errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: verilog/palette_16.mem
// palette index 0 to 15 in order, each entry is red green blue as three hex nibbles
112
F00
F80
FF0
8F0
0F0
0F8
0FF
08F
00F
80F
F0F
F08
FFF
888
444

// File: tb/tb_checks.svh
// testbench compare tasks and bounded wait loops
// included into the testbench top, works on its clock, scan position and DUT signals
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic report_mismatch(string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "stopped at first mismatch");
endtask

task automatic report_timeout(string what);
    $display("timeout while waiting for %s", what);
    $display("Errors found");
    $fatal(1, "stopped on timeout");
endtask

task automatic check_vga(vga_out_t got, vga_out_t exp, string what);
    if (got !== exp)  // shown as hsync, vsync, rgb in one hex word
        report_mismatch($sformatf("%s vga %h expected %h", what, got, exp));
endtask

task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp)
        report_mismatch($sformatf("%s is %b expected %b", what, got, exp));
endtask

task automatic check_count(int got, int exp, string what);
    if (got != exp)
        report_mismatch($sformatf("%s counted %0d expected %0d", what, got, exp));
endtask

// cycles from the call to the first low vsync sample
task automatic wait_vsync_fall(int limit, output int cycles);
    logic prev;
    cycles = 0;
    prev   = vga.vsync;
    while (!(prev && !vga.vsync)) begin
        if (cycles >= limit) report_timeout("vsync to fall");
        prev = vga.vsync;
        next_cycle();
        cycles++;
    end
endtask

task automatic wait_picture_done(int limit);
    int n;
    n = 0;
    while (!picture_done) begin
        if (n >= limit) report_timeout("picture_done");
        next_cycle();
        n++;
    end
endtask

// steps at least once, stops on the sample for position (0,0)
task automatic wait_frame_start(int limit);
    int n;
    n = 0;
    do begin
        if (n >= limit) report_timeout("start of frame");
        next_cycle();
        n++;
    end while (sx != 0 || sy != 0);
endtask

`endif

// File: tb/tb_rect_display.sv
// testbench for the rectangle display
// tracks scan position from vsync and checks the vga outputs against a pixel model
`timescale 1ns/10ps

module tb_rect_display import rect_pkg::*; ();

    localparam int FB_WIDTH  = 320;
    localparam int FB_HEIGHT = 180;
    localparam int SHAPE_CNT = 15;
    localparam int LB_TOP    = 60;   // letterbox rows 60 to 419
    localparam int LB_BOT    = 420;
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
    localparam logic [31:0] SEED = 32'hc7a5d2b5;
    localparam vga_out_t VGA_IDLE = '{hsync: 1'b1, vsync: 1'b1, rgb: '0};

    logic        clk_pix;
    logic        reset;
    vga_out_t    vga;
    logic        picture_done;
    logic [11:0] palette [16];  // own copy of the colour table
    logic [31:0] lfsr;
    int          sx;            // position the current vga sample belongs to
    int          sy;

    rect_display_top #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT),
        .SHAPE_CNT (SHAPE_CNT)
    ) UUT (
        .clk_pix,
        .reset,
        .vga,
        .picture_done
    );

    always #2 clk_pix = ~clk_pix;  // 4 ns period

    initial begin
        $readmemh(PALETTE_FILE, palette);
    end

    // outputs sampled on the falling edge, position advanced with them
    task automatic next_cycle();
        @(negedge clk_pix);
        if (sx == H_TOTAL - 1) begin
            sx = 0;
            sy = (sy == V_TOTAL - 1) ? 0 : sy + 1;
        end else begin
            sx = sx + 1;
        end
    endtask

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois, right shift
    endfunction

    function automatic int take_bits(int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // highest numbered shape covering the fb point wins, 0 if none
    function automatic cidx_t cover_index(int fx, int fy);
        cidx_t idx;
        int    i;
        idx = '0;
        for (i = 0; i < SHAPE_CNT; i++) begin
            if (fx >= 80 + 4 * i && fx <= 160 + 4 * i && fy >= 20 + 4 * i && fy <= 100 + 4 * i)
                idx = cidx_t'(i + 1);  // colour skips black
        end
        return idx;
    endfunction

    function automatic vga_out_t model_pixel(int px, int py);
        vga_out_t v;
        v.hsync = !(px >= H_ACTIVE + H_FP && px < H_ACTIVE + H_FP + H_SYNC);
        v.vsync = !(py >= V_ACTIVE + V_FP && py < V_ACTIVE + V_FP + V_SYNC);
        v.rgb   = '0;  // blanking and letterbox bands
        if (px < H_ACTIVE && py >= LB_TOP && py < LB_BOT)
            v.rgb = rgb444_t'(palette[cover_index(px / FB_SCALE, (py - LB_TOP) / FB_SCALE)]);
        return v;
    endfunction

    `include "tb_checks.svh"

    // reset seen on 4 edges, ends on the first sample after release
    task automatic reset_state();
        int i;
        @(posedge clk_pix);
        reset <= 1'b1;
        for (i = 0; i < 4; i++) begin
            @(posedge clk_pix);
            if (i == 3) reset <= 1'b0;
            @(negedge clk_pix);
            check_vga(vga, VGA_IDLE, "reset state");
            check_bit(picture_done, 1'b0, "picture_done in reset");
        end
    endtask

    task automatic sync_timing();
        int cycles;
        int low;
        int hs_low;
        wait_vsync_fall(2 * FRAME_CYC, cycles);
        // scan at (0,0) on the first sample, outputs 2 cycles late
        check_count(cycles, (V_ACTIVE + V_FP) * H_TOTAL + 2, "cycles to first vsync");
        sx     = 0;
        sy     = V_ACTIVE + V_FP;
        low    = 0;
        hs_low = 0;
        while (!vga.vsync) begin
            if (low > FRAME_CYC) report_timeout("vsync to rise");
            low++;
            if (!vga.hsync) hs_low++;
            next_cycle();
        end
        check_count(low, V_SYNC * H_TOTAL, "vsync low cycles");
        check_count(hs_low, V_SYNC * H_SYNC, "hsync low cycles in vsync");
    endtask

    task automatic drawing_completes();
        wait_picture_done(2 * FRAME_CYC);
    endtask

    task automatic full_frame_image();
        int n;
        wait_frame_start(FRAME_CYC + 1);
        for (n = 0; n < FRAME_CYC; n++) begin
            check_vga(vga, model_pixel(sx, sy), $sformatf("pixel (%0d,%0d)", sx, sy));
            check_bit(picture_done, 1'b1, "picture_done held");
            next_cycle();
        end
    endtask

    // starts on the (0,0) sample left by the full frame check
    task automatic random_spot_checks();
        int spots[$];
        int n;
        int i;
        for (i = 0; i < 40; i++) spots.push_back(take_bits(19) % FRAME_CYC);
        spots.sort();  // visit in scan order
        for (n = 0; n < FRAME_CYC; n++) begin
            while (spots.size() > 0 && spots[0] == n) begin
                check_vga(vga, model_pixel(sx, sy), $sformatf("spot (%0d,%0d)", sx, sy));
                void'(spots.pop_front());
            end
            next_cycle();
        end
    endtask

    task automatic mid_draw_reset();
        int delay;
        int n;
        reset_state();
        delay = 1000 + take_bits(14);  // redraw takes about 98k cycles
        for (n = 0; n < delay; n++) begin
            next_cycle();
            check_bit(picture_done, 1'b0, "picture_done mid-draw");
        end
        reset_state();  // drawer cut part way through a shape
        sync_timing();
        drawing_completes();
        full_frame_image();
    endtask

    initial begin
        clk_pix = 1'b0;
        reset   = 1'b1;
        lfsr    = SEED;
        sx      = 0;
        sy      = 0;
        reset_state();
        sync_timing();
        drawing_completes();
        full_frame_image();
        random_spot_checks();
        mid_draw_reset();
        $display("No errors");
        $finish;
    end

endmodule

// File: verilog/rect_display_top.sv
// filled rectangles display top level
// shape sequencer and fill drawer feed the framebuffer, 480p scan-out reads it
`timescale 1ns/10ps

module rect_display_top import rect_pkg::*; #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 180,
    parameter int SHAPE_CNT = 15
) (
    input  logic     clk_pix,
    input  logic     reset,
    output vga_out_t vga,
    output logic     picture_done
);

    localparam int FB_ADDRW = $clog2(FB_WIDTH * FB_HEIGHT);

    logic                frame;       // scan-out start of frame
    logic                draw_start;
    logic                draw_done;
    rect_t               rect;
    cidx_t               draw_cidx;
    fb_write_t           fb_wr;       // drawer to framebuffer
    logic [FB_ADDRW-1:0] rd_addr;     // scan-out to framebuffer
    cidx_t               rd_cidx;

    shape_sequencer #(.SHAPE_CNT(SHAPE_CNT)) seq_inst (
        .clk_pix,
        .reset,
        .frame,
        .draw_done,
        .draw_start,
        .rect,
        .draw_cidx,
        .picture_done
    );

    rect_fill_drawer drawer_inst (
        .clk_pix,
        .reset,
        .start   (draw_start),
        .rect,
        .cidx    (draw_cidx),
        .fb_wr,
        .drawing (),          // same as fb_wr.we
        .done    (draw_done)
    );

    framebuffer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) fb_inst (
        .clk_pix,
        .fb_wr,
        .rd_addr,
        .rd_cidx
    );

    scanout_480p #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) scan_inst (
        .clk_pix,
        .reset,
        .rd_cidx,
        .rd_addr,
        .frame,
        .vga
    );

endmodule

// File: verilog/scanout_480p.sv
// 480p scan-out
// timing counters and syncs, letterboxed 2x framebuffer read, palette lookup
`timescale 1ns/10ps

module scanout_480p import rect_pkg::*; #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 180
) (
    input  logic                                   clk_pix,
    input  logic                                   reset,
    input  cidx_t                                  rd_cidx,  // from framebuffer
    output logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0]  rd_addr,
    output logic                                   frame,    // pulse at (0,0)
    output vga_out_t                               vga       // 2 cycles behind position
);

    localparam int FB_ADDRW = $clog2(FB_WIDTH * FB_HEIGHT);
    localparam int LB_ROWS  = FB_HEIGHT * FB_SCALE;        // 360 screen rows
    localparam int LB_FIRST = (V_ACTIVE - LB_ROWS) / 2;    // 60

    localparam coord_t H_LAST   = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST   = coord_t'(V_TOTAL - 1);
    localparam coord_t H_ACT    = coord_t'(H_ACTIVE);
    localparam coord_t HS_START = coord_t'(H_ACTIVE + H_FP);
    localparam coord_t HS_END   = coord_t'(H_ACTIVE + H_FP + H_SYNC);
    localparam coord_t VS_START = coord_t'(V_ACTIVE + V_FP);
    localparam coord_t VS_END   = coord_t'(V_ACTIVE + V_FP + V_SYNC);
    localparam coord_t LB_TOP   = coord_t'(LB_FIRST);
    localparam coord_t LB_BOT   = coord_t'(LB_FIRST + LB_ROWS);  // 420, exclusive
    localparam coord_t SCALE_C  = coord_t'(FB_SCALE);
    localparam logic [FB_ADDRW-1:0] FB_W_A = FB_ADDRW'(FB_WIDTH);

    screen_pos_t pos;  // current scan position
    logic        hsync;
    logic        vsync;
    logic        de;   // inside letterbox picture
    coord_t      fb_x;
    coord_t      fb_y;
    logic        hsync_p1;  // matched to framebuffer read latency
    logic        vsync_p1;
    logic        de_p1;

    logic [11:0] palette [16];  // 4 bits each of r, g, b

    initial begin
        $readmemh(PALETTE_FILE, palette);
    end

    // horizontal and vertical counters
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            pos.sx <= '0;
            pos.sy <= '0;
        end else if (pos.sx == H_LAST) begin
            pos.sx <= '0;
            pos.sy <= (pos.sy == V_LAST) ? '0 : pos.sy + 16'sd1;  // wrap at end of frame
        end else begin
            pos.sx <= pos.sx + 16'sd1;
        end
    end

    assign frame = (pos.sx == 16'sd0) && (pos.sy == 16'sd0);

    // syncs are active low
    assign hsync = ~((pos.sx >= HS_START) && (pos.sx < HS_END));
    assign vsync = ~((pos.sy >= VS_START) && (pos.sy < VS_END));

    // 16:9 letterbox inside 4:3 active area
    assign de = (pos.sx < H_ACT) && (pos.sy >= LB_TOP) && (pos.sy < LB_BOT);

    // screen to fb coordinates, halved
    assign fb_x = pos.sx / SCALE_C;
    assign fb_y = (pos.sy - LB_TOP) / SCALE_C;

    // parked at 0 outside picture
    assign rd_addr = de ? FB_ADDRW'(fb_y) * FB_W_A + FB_ADDRW'(fb_x) : '0;

    // stage 1: wait for read data
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync_p1 <= 1'b1;
            vsync_p1 <= 1'b1;
            de_p1    <= 1'b0;
        end else begin
            hsync_p1 <= hsync;
            vsync_p1 <= vsync;
            de_p1    <= de;
        end
    end

    // stage 2: palette lookup and output registers
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vga.hsync <= 1'b1;
            vga.vsync <= 1'b1;
            vga.rgb   <= '0;
        end else begin
            vga.hsync <= hsync_p1;
            vga.vsync <= vsync_p1;
            vga.rgb   <= de_p1 ? rgb444_t'(palette[rd_cidx]) : '0;  // black in bands
        end
    end

endmodule

// File: verilog/framebuffer.sv
// indexed colour framebuffer
// simple dual-port memory, clipped write port and registered read port
`timescale 1ns/10ps

module framebuffer import rect_pkg::*; #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 180
) (
    input  logic                                   clk_pix,
    input  fb_write_t                              fb_wr,
    input  logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0]  rd_addr,
    output cidx_t                                  rd_cidx  // one cycle after rd_addr
);

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);

    localparam coord_t FB_W_C = coord_t'(FB_WIDTH);
    localparam coord_t FB_H_C = coord_t'(FB_HEIGHT);
    localparam logic [FB_ADDRW-1:0] FB_W_A = FB_ADDRW'(FB_WIDTH);

    cidx_t mem [FB_PIXELS] = '{default: '0};  // starts all black

    logic                wr_inside;
    logic [FB_ADDRW-1:0] wr_addr;

    // clip anything off the buffer
    assign wr_inside = (fb_wr.x >= 16'sd0) && (fb_wr.x < FB_W_C)
                    && (fb_wr.y >= 16'sd0) && (fb_wr.y < FB_H_C);

    // row major address, only valid when inside
    assign wr_addr = FB_ADDRW'(fb_wr.y) * FB_W_A + FB_ADDRW'(fb_wr.x);

    // write port
    always_ff @(posedge clk_pix) begin
        if (fb_wr.we && wr_inside) begin
            mem[wr_addr] <= fb_wr.cidx;
        end
    end

    // read port, registered
    always_ff @(posedge clk_pix) begin
        rd_cidx <= mem[rd_addr];
    end

endmodule

// File: verilog/rect_fill_drawer.sv
// rectangle fill drawer
// walks every pixel of a rectangle row by row, one framebuffer write per cycle
`timescale 1ns/10ps

module rect_fill_drawer import rect_pkg::*; (
    input  logic      clk_pix,
    input  logic      reset,
    input  logic      start,    // one cycle pulse
    input  rect_t     rect,     // sampled in DR_INIT
    input  cidx_t     cidx,     // sampled in DR_INIT
    output fb_write_t fb_wr,
    output logic      drawing,  // high while writing
    output logic      done      // pulse after last pixel
);

    draw_state_t state;

    rect_t  corners;  // captured rectangle
    cidx_t  colour;
    coord_t x;        // current pixel
    coord_t y;
    logic   row_end;
    logic   last_pix;

    assign row_end  = (x == corners.x1);
    assign last_pix = row_end && (y == corners.y1);

    // control FSM
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state <= DR_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                DR_IDLE: begin
                    if (start) state <= DR_INIT;
                end
                DR_INIT: begin
                    state <= DR_DRAW;
                end
                DR_DRAW: begin
                    if (last_pix) begin
                        state <= DR_IDLE;
                        done  <= 1'b1;  // lands the cycle after last write
                    end
                end
                default: state <= DR_IDLE;
            endcase
        end
    end

    // pixel stepping
    always_ff @(posedge clk_pix) begin
        case (state)
            DR_INIT: begin
                corners <= rect;
                colour  <= cidx;
                x       <= rect.x0;  // top left corner first
                y       <= rect.y0;
            end
            DR_DRAW: begin
                if (row_end) begin
                    x <= corners.x0;   // back to left edge
                    y <= y + 16'sd1;   // next row
                end else begin
                    x <= x + 16'sd1;
                end
            end
            default: ;
        endcase
    end

    // exactly one write per pixel while in DR_DRAW
    assign fb_wr.we   = (state == DR_DRAW);
    assign fb_wr.x    = x;
    assign fb_wr.y    = y;
    assign fb_wr.cidx = colour;
    assign drawing    = fb_wr.we;

endmodule

// File: verilog/shape_sequencer.sv
// shape sequencer
// waits for first frame, then hands each rectangle to the fill drawer in turn
`timescale 1ns/10ps

module shape_sequencer import rect_pkg::*; #(
    parameter int SHAPE_CNT = 15  // at most 15, index 0 is black
) (
    input  logic  clk_pix,
    input  logic  reset,
    input  logic  frame,         // start of frame from scan-out
    input  logic  draw_done,     // drawer finished current shape
    output logic  draw_start,    // one cycle pulse
    output rect_t rect,          // held until draw_done
    output cidx_t draw_cidx,
    output logic  picture_done   // level, stays high until reset
);

    localparam logic [3:0] LAST_ID = 4'(SHAPE_CNT - 1);

    seq_state_t state;
    logic [3:0] shape_id;  // current shape

    // control FSM
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state    <= SEQ_IDLE;
            shape_id <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (frame) state <= SEQ_INIT;  // wait for scan-out
                end
                SEQ_INIT: begin
                    state <= SEQ_DRAW;  // start pulse goes out here
                end
                SEQ_DRAW: begin
                    if (draw_done) begin
                        if (shape_id == LAST_ID) begin
                            state <= SEQ_DONE;
                        end else begin
                            shape_id <= shape_id + 4'd1;
                            state    <= SEQ_INIT;
                        end
                    end
                end
                SEQ_DONE: begin
                    state <= SEQ_DONE;  // picture is drawn once only
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // shape geometry, each one shifted 4 px down and right
    always_ff @(posedge clk_pix) begin
        if (state == SEQ_INIT) begin
            rect.x0   <= coord_t'(80 + 4 * shape_id);
            rect.y0   <= coord_t'(20 + 4 * shape_id);
            rect.x1   <= coord_t'(160 + 4 * shape_id);
            rect.y1   <= coord_t'(100 + 4 * shape_id);
            draw_cidx <= cidx_t'(shape_id + 4'd1);  // skip black
        end
    end

    // drawer latches rect in its own init cycle, one after this pulse
    assign draw_start   = (state == SEQ_INIT);
    assign picture_done = (state == SEQ_DONE);

endmodule

// File: verilog/rect_pkg.sv
// rect display shared definitions
// display timing, coordinate and colour types, bus structs, FSM states
package rect_pkg;

    localparam int CORDW = 16;  // coordinate width

    typedef logic signed [CORDW-1:0] coord_t;  // screen or fb coordinate
    typedef logic [3:0] cidx_t;                // colour index

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb444_t;

    typedef struct packed {
        logic    hsync;  // active low
        logic    vsync;  // active low
        rgb444_t rgb;
    } vga_out_t;

    // inclusive corners, x0 <= x1 and y0 <= y1
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
    } rect_t;

    typedef struct packed {
        logic   we;
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } fb_write_t;

    typedef struct packed {
        coord_t sx;
        coord_t sy;
    } screen_pos_t;

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_INIT, SEQ_DRAW, SEQ_DONE} seq_state_t;
    typedef enum logic [1:0] {DR_IDLE, DR_INIT, DR_DRAW} draw_state_t;

    // 640x480 at 60 Hz, 25.2 MHz pixel clock
    localparam int H_ACTIVE = 640;
    localparam int H_FP     = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BP     = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;  // 800

    localparam int V_ACTIVE = 480;
    localparam int V_FP     = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;  // 525

    localparam int FB_SCALE = 2;  // fb pixel is 2x2 screen pixels

    localparam string PALETTE_FILE = "palette_16.mem";

endpackage
